// File: mips_pkg.sv
package mips_pkg;

    localparam int isa_width       = 32;  // data and instruction width
    localparam int reg_addr_width  = 5;   // 32 registers
    localparam int jump_addr_width = 26;  // j and jal target field
    localparam int link_reg        = 31;  // jal return register
    localparam int link_offset     = 4;   // return address = pc + 4

    typedef enum logic [5:0] {
        op_rtype = 6'd0,
        op_j     = 6'd2,
        op_jal   = 6'd3,
        op_beq   = 6'd4,
        op_bne   = 6'd5,
        op_blez  = 6'd6,
        op_bgtz  = 6'd7,
        op_addi  = 6'd8,
        op_slti  = 6'd10,
        op_andi  = 6'd12,
        op_ori   = 6'd13,
        op_xori  = 6'd14,
        op_lui   = 6'd15,
        op_lw    = 6'd35,
        op_sw    = 6'd43
    } opcode_e;

    typedef enum logic [5:0] {
        fn_sll = 6'd0,
        fn_jr  = 6'd8,
        fn_add = 6'd32,
        fn_sub = 6'd34,
        fn_and = 6'd36,
        fn_or  = 6'd37,
        fn_xor = 6'd38,
        fn_slt = 6'd42
    } funct_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or,
        alu_xor, alu_slt, alu_sll, alu_lui
    } alu_op_e;

endpackage

// File: control_unit.sv
module control_unit import mips_pkg::*; (
    input  logic [isa_width-1:0] instruction,   // from IF/ID
    output logic                 i_type_instruction,
    output logic                 r_type_instruction,
    output logic                 j_instruction,
    output logic                 jr_instruction,
    output logic                 jal_instruction,
    output logic                 branch_instruction,
    output logic                 store_instruction,
    output logic                 load_instruction,
    output logic                 reg_write,     // writeback enable for later stages
    output alu_op_e              alu_op,
    output logic [isa_width-1:0] extend_result  // 16 bit immediate, extended
);

    opcode_e opcode;
    funct_e  funct;
    logic    zero_ext;

    assign opcode = opcode_e'(instruction[31:26]);
    assign funct  = funct_e'(instruction[5:0]);

    // logical immediates are zero extended, all others sign extended
    assign zero_ext      = (opcode == op_andi) || (opcode == op_ori) || (opcode == op_xori);
    assign extend_result = zero_ext ? {16'b0, instruction[15:0]}
                                    : {{16{instruction[15]}}, instruction[15:0]};

    always_comb begin
        i_type_instruction = 1'b0;
        r_type_instruction = 1'b0;
        j_instruction      = 1'b0;
        jr_instruction     = 1'b0;
        jal_instruction    = 1'b0;
        branch_instruction = 1'b0;
        store_instruction  = 1'b0;
        load_instruction   = 1'b0;
        alu_op             = alu_add;  // address and link arithmetic default
        case (opcode)
            op_rtype: begin
                if (funct == fn_jr) begin
                    jr_instruction = 1'b1;  // jr is not counted as R type
                end else begin
                    r_type_instruction = 1'b1;
                    case (funct)
                        fn_sub:  alu_op = alu_sub;
                        fn_and:  alu_op = alu_and;
                        fn_or:   alu_op = alu_or;
                        fn_xor:  alu_op = alu_xor;
                        fn_slt:  alu_op = alu_slt;
                        fn_sll:  alu_op = alu_sll;
                        default: alu_op = alu_add;
                    endcase
                end
            end
            op_j:    j_instruction = 1'b1;
            op_jal:  jal_instruction = 1'b1;  // alu computes pc + 4
            op_beq, op_bne, op_blez, op_bgtz: begin
                branch_instruction = 1'b1;
                alu_op             = alu_sub;
            end
            op_addi: i_type_instruction = 1'b1;
            op_slti: begin
                i_type_instruction = 1'b1;
                alu_op             = alu_slt;
            end
            op_andi: begin
                i_type_instruction = 1'b1;
                alu_op             = alu_and;
            end
            op_ori: begin
                i_type_instruction = 1'b1;
                alu_op             = alu_or;
            end
            op_xori: begin
                i_type_instruction = 1'b1;
                alu_op             = alu_xor;
            end
            op_lui: begin
                i_type_instruction = 1'b1;
                alu_op             = alu_lui;  // shift by 16 done in execute
            end
            op_lw: begin
                i_type_instruction = 1'b1;
                load_instruction   = 1'b1;
            end
            op_sw:   store_instruction = 1'b1;
            default: ;  // unknown opcode raises nothing
        endcase
    end

    assign reg_write = r_type_instruction | i_type_instruction | jal_instruction;

endmodule

// File: register_file.sv
module register_file import mips_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [reg_addr_width-1:0] read_idx_1,   // rs
    input  logic [reg_addr_width-1:0] read_idx_2,   // rt
    output logic [isa_width-1:0]      read_data_1,
    output logic [isa_width-1:0]      read_data_2,
    input  logic                      write_en,     // writeback strobe
    input  logic [reg_addr_width-1:0] write_idx,
    input  logic [isa_width-1:0]      write_data
);

    logic [isa_width-1:0] regs [2**reg_addr_width];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**reg_addr_width; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && write_idx != '0) begin
            regs[write_idx] <= write_data;  // r0 stays 0
        end
    end

    // same cycle write is bypassed to the readers
    function automatic logic [isa_width-1:0] read_port(input logic [reg_addr_width-1:0] idx);
        if (idx == '0) begin
            return '0;
        end else if (write_en && write_idx == idx) begin
            return write_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        read_data_1 = read_port(read_idx_1);
        read_data_2 = read_port(read_idx_2);
    end

endmodule

// File: condition_check.sv
module condition_check import mips_pkg::*; (
    input  logic [isa_width-1:0] instruction,
    input  logic [isa_width-1:0] reg_1,          // rs value
    input  logic [isa_width-1:0] reg_2,          // rt value
    output logic                 condition_satisfied
);

    opcode_e opcode;
    logic    equal;
    logic    le_zero;  // signed reg_1 <= 0

    assign opcode  = opcode_e'(instruction[31:26]);
    assign equal   = (reg_1 == reg_2);
    assign le_zero = reg_1[isa_width-1] || (reg_1 == '0);

    always_comb begin
        case (opcode)
            op_beq:  condition_satisfied = equal;
            op_bne:  condition_satisfied = !equal;
            op_blez: condition_satisfied = le_zero;
            op_bgtz: condition_satisfied = !le_zero;
            default: condition_satisfied = 1'b0;  // not a branch
        endcase
    end

endmodule

// File: id_mux.sv
module id_mux import mips_pkg::*; (
    input  logic                      i_type_instruction,
    input  logic                      r_type_instruction,
    input  logic                      j_instruction,
    input  logic                      jr_instruction,
    input  logic                      jal_instruction,
    input  logic                      branch_instruction,
    input  logic                      store_instruction,
    input  logic                      load_instruction,
    input  logic                      condition_satisfied,  // from condition_check
    input  logic [isa_width-1:0]      id_reg_1,             // rs value
    input  logic [isa_width-1:0]      id_reg_2,             // rt value
    input  logic [isa_width-1:0]      id_pc,
    input  logic [isa_width-1:0]      id_instruction,
    input  logic [isa_width-1:0]      id_extend_result,
    input  logic [reg_addr_width-1:0] id_reg_1_idx,         // rs
    input  logic [reg_addr_width-1:0] id_reg_2_idx,         // rt
    input  logic [reg_addr_width-1:0] id_reg_dest_idx,      // rd
    output logic                      pc_offset,            // taken branch, fetch adds offset
    output logic                      pc_overload,          // jump, fetch loads new pc
    output logic [isa_width-1:0]      pc_overload_value,
    output logic [isa_width-1:0]      pc_offset_value,
    output logic [isa_width-1:0]      mux_operand_1,
    output logic [isa_width-1:0]      mux_operand_2,
    output logic [reg_addr_width-1:0] mux_reg_1_idx,        // to hazard and forwarding
    output logic [reg_addr_width-1:0] mux_reg_2_idx,
    output logic [reg_addr_width-1:0] mux_reg_dest_idx,
    output logic                      reg_1_valid,
    output logic                      reg_2_valid
);

    logic jump_direct;  // j or jal
    logic no_dest;      // store or branch

    assign jump_direct = j_instruction | jal_instruction;
    assign no_dest     = store_instruction | branch_instruction;

    assign pc_offset         = branch_instruction & condition_satisfied;
    assign pc_overload       = jump_direct | jr_instruction;
    assign pc_overload_value = jump_direct ? {id_pc[isa_width-1:jump_addr_width+2],
                                              id_instruction[jump_addr_width-1:0], 2'b00}
                                           : id_reg_1;  // jr target from rs
    assign pc_offset_value   = {id_extend_result[isa_width-3:0], 2'b00};  // word offset

    assign mux_operand_1 = jal_instruction ? id_pc : id_reg_1;
    assign mux_operand_2 = i_type_instruction ? id_extend_result :
                           jal_instruction    ? isa_width'(link_offset) : id_reg_2;

    assign reg_1_valid   = !jump_direct;
    assign reg_2_valid   = r_type_instruction | no_dest;
    assign mux_reg_1_idx = reg_1_valid ? id_reg_1_idx : '0;
    assign mux_reg_2_idx = reg_2_valid ? id_reg_2_idx : '0;

    always_comb begin
        if (i_type_instruction || load_instruction) begin
            mux_reg_dest_idx = id_reg_2_idx;  // I type writes rt
        end else if (no_dest) begin
            mux_reg_dest_idx = '0;
        end else if (jal_instruction) begin
            mux_reg_dest_idx = reg_addr_width'(link_reg);
        end else if (jr_instruction || j_instruction) begin
            mux_reg_dest_idx = '0;  // jumps without link write nothing
        end else begin
            mux_reg_dest_idx = id_reg_dest_idx;  // R type writes rd
        end
    end

endmodule

// File: id_ex_reg.sv
module id_ex_reg import mips_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      stall,              // hold contents
    input  logic                      flush,              // load bubble, beats stall
    input  logic [isa_width-1:0]      mux_operand_1,
    input  logic [isa_width-1:0]      mux_operand_2,
    input  logic [isa_width-1:0]      id_reg_2,           // store data
    input  logic [reg_addr_width-1:0] mux_reg_1_idx,
    input  logic [reg_addr_width-1:0] mux_reg_2_idx,
    input  logic [reg_addr_width-1:0] mux_reg_dest_idx,
    input  alu_op_e                   alu_op,
    input  logic                      reg_write,
    input  logic                      load_instruction,
    input  logic                      store_instruction,
    input  logic                      branch_instruction,
    input  logic                      j_instruction,
    input  logic                      jr_instruction,
    output logic [isa_width-1:0]      ex_operand_1,
    output logic [isa_width-1:0]      ex_operand_2,
    output logic [isa_width-1:0]      ex_store_data,
    output logic [reg_addr_width-1:0] ex_reg_1_idx,
    output logic [reg_addr_width-1:0] ex_reg_2_idx,
    output logic [reg_addr_width-1:0] ex_dest_idx,
    output alu_op_e                   ex_alu_op,
    output logic                      ex_reg_write,
    output logic                      ex_mem_read,
    output logic                      ex_mem_write,
    output logic                      ex_valid
);

    logic decoded;  // some class flag raised, reg_write covers R, I and jal

    assign decoded = reg_write | store_instruction | branch_instruction
                   | j_instruction | jr_instruction;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin  // bubble
            ex_operand_1  <= '0;
            ex_operand_2  <= '0;
            ex_store_data <= '0;
            ex_reg_1_idx  <= '0;
            ex_reg_2_idx  <= '0;
            ex_dest_idx   <= '0;
            ex_alu_op     <= alu_add;
            ex_reg_write  <= 1'b0;
            ex_mem_read   <= 1'b0;
            ex_mem_write  <= 1'b0;
            ex_valid      <= 1'b0;
        end else if (flush) begin  // bubble at the edge, stall ignored
            ex_operand_1  <= '0;
            ex_operand_2  <= '0;
            ex_store_data <= '0;
            ex_reg_1_idx  <= '0;
            ex_reg_2_idx  <= '0;
            ex_dest_idx   <= '0;
            ex_alu_op     <= alu_add;
            ex_reg_write  <= 1'b0;
            ex_mem_read   <= 1'b0;
            ex_mem_write  <= 1'b0;
            ex_valid      <= 1'b0;
        end else if (!stall) begin
            ex_operand_1  <= mux_operand_1;
            ex_operand_2  <= mux_operand_2;
            ex_store_data <= id_reg_2;
            ex_reg_1_idx  <= mux_reg_1_idx;
            ex_reg_2_idx  <= mux_reg_2_idx;
            ex_dest_idx   <= mux_reg_dest_idx;
            ex_alu_op     <= alu_op;
            ex_reg_write  <= reg_write;
            ex_mem_read   <= load_instruction;
            ex_mem_write  <= store_instruction;
            ex_valid      <= decoded;
        end
    end

endmodule

// File: decode_stage.sv
module decode_stage import mips_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      stall,
    input  logic                      flush,
    input  logic [isa_width-1:0]      id_instruction,    // from IF/ID
    input  logic [isa_width-1:0]      id_pc,
    input  logic                      wb_write_en,       // writeback port
    input  logic [reg_addr_width-1:0] wb_idx,
    input  logic [isa_width-1:0]      wb_data,
    output logic                      pc_offset,         // redirect to fetch
    output logic                      pc_overload,
    output logic [isa_width-1:0]      pc_overload_value,
    output logic [isa_width-1:0]      pc_offset_value,
    output logic                      reg_1_valid,       // to hazard unit
    output logic                      reg_2_valid,
    output logic [reg_addr_width-1:0] mux_reg_1_idx,
    output logic [reg_addr_width-1:0] mux_reg_2_idx,
    output logic [reg_addr_width-1:0] mux_reg_dest_idx,
    output logic [isa_width-1:0]      ex_operand_1,      // ID/EX contents
    output logic [isa_width-1:0]      ex_operand_2,
    output logic [isa_width-1:0]      ex_store_data,
    output logic [reg_addr_width-1:0] ex_reg_1_idx,
    output logic [reg_addr_width-1:0] ex_reg_2_idx,
    output logic [reg_addr_width-1:0] ex_dest_idx,
    output alu_op_e                   ex_alu_op,
    output logic                      ex_reg_write,
    output logic                      ex_mem_read,
    output logic                      ex_mem_write,
    output logic                      ex_valid
);

    logic i_type, r_type, j_ins, jr_ins, jal_ins, branch_ins, store_ins, load_ins;
    logic reg_write, cond_ok;
    alu_op_e alu_op;
    logic [isa_width-1:0] extend_result, reg_1, reg_2, operand_1, operand_2;

    control_unit ctrl_i (
        .instruction(id_instruction), .i_type_instruction(i_type),
        .r_type_instruction(r_type), .j_instruction(j_ins), .jr_instruction(jr_ins),
        .jal_instruction(jal_ins), .branch_instruction(branch_ins),
        .store_instruction(store_ins), .load_instruction(load_ins),
        .reg_write(reg_write), .alu_op(alu_op), .extend_result(extend_result)
    );

    register_file regs_i (
        .clk(clk), .rst_n(rst_n),
        .read_idx_1(id_instruction[25:21]), .read_idx_2(id_instruction[20:16]),
        .read_data_1(reg_1), .read_data_2(reg_2),
        .write_en(wb_write_en), .write_idx(wb_idx), .write_data(wb_data)
    );

    condition_check cond_i (
        .instruction(id_instruction), .reg_1(reg_1), .reg_2(reg_2),
        .condition_satisfied(cond_ok)
    );

    id_mux mux_i (
        .i_type_instruction(i_type), .r_type_instruction(r_type), .j_instruction(j_ins),
        .jr_instruction(jr_ins), .jal_instruction(jal_ins),
        .branch_instruction(branch_ins), .store_instruction(store_ins),
        .load_instruction(load_ins), .condition_satisfied(cond_ok),
        .id_reg_1(reg_1), .id_reg_2(reg_2), .id_pc(id_pc), .id_instruction(id_instruction),
        .id_extend_result(extend_result), .id_reg_1_idx(id_instruction[25:21]),
        .id_reg_2_idx(id_instruction[20:16]), .id_reg_dest_idx(id_instruction[15:11]),
        .pc_offset(pc_offset), .pc_overload(pc_overload),
        .pc_overload_value(pc_overload_value), .pc_offset_value(pc_offset_value),
        .mux_operand_1(operand_1), .mux_operand_2(operand_2),
        .mux_reg_1_idx(mux_reg_1_idx), .mux_reg_2_idx(mux_reg_2_idx),
        .mux_reg_dest_idx(mux_reg_dest_idx), .reg_1_valid(reg_1_valid),
        .reg_2_valid(reg_2_valid)
    );

    id_ex_reg id_ex_i (
        .clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush),
        .mux_operand_1(operand_1), .mux_operand_2(operand_2), .id_reg_2(reg_2),
        .mux_reg_1_idx(mux_reg_1_idx), .mux_reg_2_idx(mux_reg_2_idx),
        .mux_reg_dest_idx(mux_reg_dest_idx), .alu_op(alu_op), .reg_write(reg_write),
        .load_instruction(load_ins), .store_instruction(store_ins),
        .branch_instruction(branch_ins), .j_instruction(j_ins), .jr_instruction(jr_ins),
        .ex_operand_1(ex_operand_1), .ex_operand_2(ex_operand_2),
        .ex_store_data(ex_store_data), .ex_reg_1_idx(ex_reg_1_idx),
        .ex_reg_2_idx(ex_reg_2_idx), .ex_dest_idx(ex_dest_idx), .ex_alu_op(ex_alu_op),
        .ex_reg_write(ex_reg_write), .ex_mem_read(ex_mem_read),
        .ex_mem_write(ex_mem_write), .ex_valid(ex_valid)
    );

endmodule

// File: tb_decode_stage.sv
module tb_decode_stage import mips_pkg::*; ();

    logic clk = 1'b0;
    logic rst_n, stall, flush, wb_write_en;
    logic [isa_width-1:0] id_instruction, id_pc, wb_data;
    logic [reg_addr_width-1:0] wb_idx;
    logic pc_offset, pc_overload, reg_1_valid, reg_2_valid;
    logic ex_reg_write, ex_mem_read, ex_mem_write, ex_valid;
    logic [isa_width-1:0] pc_overload_value, pc_offset_value;
    logic [isa_width-1:0] ex_operand_1, ex_operand_2, ex_store_data;
    logic [reg_addr_width-1:0] mux_reg_1_idx, mux_reg_2_idx, mux_reg_dest_idx;
    logic [reg_addr_width-1:0] ex_reg_1_idx, ex_reg_2_idx, ex_dest_idx;
    alu_op_e ex_alu_op;

    logic [31:0] mirror [32];           // expected register file contents
    logic [31:0] lfsr_state;
    logic [31:0] tbl_ins[$], tbl_pc[$];  // stimulus table
    logic tbl_stall[$], tbl_flush[$];
    int checks = 0;
    int errors = 0;
    int cycles = 0;
    int cycle_limit = 100000;            // replaced once the table is built

    // expected combinational outputs
    logic c_offset, c_overload, c_r1v, c_r2v;
    logic [31:0] c_ovl_value, c_off_value;
    logic [4:0] c_r1_idx, c_r2_idx, c_dest;
    // expected ID/EX contents, p_ for the current row and e_ for the register
    logic [31:0] p_op1, p_op2, p_store, e_op1, e_op2, e_store;
    logic [4:0] e_r1_idx, e_r2_idx, e_dest;
    alu_op_e p_alu, e_alu;
    logic p_alu_chk, p_rw, p_mr, p_mw, p_valid;
    logic e_alu_chk, e_rw, e_mr, e_mw, e_valid;

    decode_stage dut_i (.*);

    always #4 clk = ~clk;  // period 8

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // galois taps 32,22,2,1
    endfunction

    task automatic random_word(output logic [31:0] w);
        for (int b = 0; b < 32; b++) begin
            lfsr_state = lfsr_next(lfsr_state);  // one step per bit
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] r_ins(funct_e fn, logic [4:0] rs, rt, rd);
        return {op_rtype, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_ins(opcode_e op, logic [4:0] rs, rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_ins(opcode_e op, logic [25:0] target);
        return {op, target};
    endfunction

    task automatic add_row(input logic [31:0] ins, pc, input logic s, f);
        tbl_ins.push_back(ins);
        tbl_pc.push_back(pc);
        tbl_stall.push_back(s);
        tbl_flush.push_back(f);
    endtask

    task automatic check_val(input string what, input logic [31:0] act, exp);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("FAILED %0t: %s is %h, expected %h", $time, what, act, exp);
        end
    endtask

    // expected values straight from the decode rules and the mirror
    task automatic predict(input logic [31:0] ins, pc);
        opcode_e op;
        funct_e fn;
        logic [4:0] rs, rt, rd;
        logic [31:0] a, b, ext;
        logic is_r, is_i, is_j, is_jal, is_jr, is_br, is_st, is_ld, cond;
        op = opcode_e'(ins[31:26]);
        fn = funct_e'(ins[5:0]);
        rs = ins[25:21];
        rt = ins[20:16];
        rd = ins[15:11];
        a = mirror[rs];
        b = mirror[rt];
        is_jr = (op == op_rtype) && (fn == fn_jr);
        is_r = (op == op_rtype) && !is_jr;
        is_j = (op == op_j);
        is_jal = (op == op_jal);
        is_br = op inside {op_beq, op_bne, op_blez, op_bgtz};
        is_st = (op == op_sw);
        is_ld = (op == op_lw);
        is_i = op inside {op_addi, op_slti, op_andi, op_ori, op_xori, op_lui, op_lw};
        ext = (op inside {op_andi, op_ori, op_xori}) ? {16'h0, ins[15:0]}
                                                    : {{16{ins[15]}}, ins[15:0]};
        case (op)
            op_beq:  cond = (a == b);
            op_bne:  cond = (a != b);
            op_blez: cond = ($signed(a) <= 0);
            op_bgtz: cond = ($signed(a) > 0);
            default: cond = 1'b0;
        endcase
        c_offset = is_br && cond;
        c_overload = is_j || is_jal || is_jr;
        c_ovl_value = (is_j || is_jal) ? {pc[31:28], ins[25:0], 2'b00} : a;
        c_off_value = ext << 2;
        c_r1v = !(is_j || is_jal);
        c_r2v = is_r || is_st || is_br;
        c_r1_idx = c_r1v ? rs : 5'd0;
        c_r2_idx = c_r2v ? rt : 5'd0;
        if (is_i) c_dest = rt;
        else if (is_st || is_br || is_jr || is_j) c_dest = 5'd0;
        else if (is_jal) c_dest = 5'd31;
        else c_dest = rd;
        p_op1 = is_jal ? pc : a;
        p_op2 = is_i ? ext : (is_jal ? 32'd4 : b);
        p_store = b;
        p_alu_chk = is_r || is_i;  // alu op only defined for R and I type
        case (op)
            op_slti: p_alu = alu_slt;
            op_andi: p_alu = alu_and;
            op_ori:  p_alu = alu_or;
            op_xori: p_alu = alu_xor;
            op_lui:  p_alu = alu_lui;
            default: p_alu = alu_add;  // addi, lw
        endcase
        if (is_r) begin
            case (fn)
                fn_sub:  p_alu = alu_sub;
                fn_and:  p_alu = alu_and;
                fn_or:   p_alu = alu_or;
                fn_xor:  p_alu = alu_xor;
                fn_slt:  p_alu = alu_slt;
                fn_sll:  p_alu = alu_sll;
                default: p_alu = alu_add;
            endcase
        end
        p_rw = is_r || is_i || is_jal;
        p_mr = is_ld;
        p_mw = is_st;
        p_valid = is_r || is_i || is_j || is_jal || is_jr || is_br || is_st;
    endtask

    task automatic load_bubble();
        e_op1 = '0;
        e_op2 = '0;
        e_store = '0;
        e_r1_idx = '0;
        e_r2_idx = '0;
        e_dest = '0;
        e_alu = alu_add;
        e_alu_chk = 1'b1;
        {e_rw, e_mr, e_mw, e_valid} = 4'b0000;
    endtask

    task automatic check_comb();
        check_val("pc_offset", 32'(pc_offset), 32'(c_offset));
        check_val("pc_overload", 32'(pc_overload), 32'(c_overload));
        if (c_overload) check_val("pc_overload_value", pc_overload_value, c_ovl_value);
        check_val("pc_offset_value", pc_offset_value, c_off_value);
        check_val("reg_1_valid", 32'(reg_1_valid), 32'(c_r1v));
        check_val("reg_2_valid", 32'(reg_2_valid), 32'(c_r2v));
        check_val("mux_reg_1_idx", 32'(mux_reg_1_idx), 32'(c_r1_idx));
        check_val("mux_reg_2_idx", 32'(mux_reg_2_idx), 32'(c_r2_idx));
        check_val("mux_reg_dest_idx", 32'(mux_reg_dest_idx), 32'(c_dest));
    endtask

    task automatic check_ex();
        check_val("ex_operand_1", ex_operand_1, e_op1);
        check_val("ex_operand_2", ex_operand_2, e_op2);
        check_val("ex_store_data", ex_store_data, e_store);
        check_val("ex_reg_1_idx", 32'(ex_reg_1_idx), 32'(e_r1_idx));
        check_val("ex_reg_2_idx", 32'(ex_reg_2_idx), 32'(e_r2_idx));
        check_val("ex_dest_idx", 32'(ex_dest_idx), 32'(e_dest));
        if (e_alu_chk) check_val("ex_alu_op", 32'(ex_alu_op), 32'(e_alu));
        check_val("ex_reg_write", 32'(ex_reg_write), 32'(e_rw));
        check_val("ex_mem_read", 32'(ex_mem_read), 32'(e_mr));
        check_val("ex_mem_write", 32'(ex_mem_write), 32'(e_mw));
        check_val("ex_valid", 32'(ex_valid), 32'(e_valid));
    endtask

    // entered 1 after a rising edge, left 1 after the next one
    task automatic step_row(input logic [31:0] ins, pc, input logic s, f);
        id_instruction = ins;
        id_pc = pc;
        stall = s;
        flush = f;
        predict(ins, pc);
        if (f) begin
            load_bubble();  // flush beats stall
        end else if (!s) begin
            {e_op1, e_op2, e_store} = {p_op1, p_op2, p_store};
            {e_r1_idx, e_r2_idx, e_dest} = {c_r1_idx, c_r2_idx, c_dest};
            e_alu = p_alu;
            {e_alu_chk, e_rw, e_mr, e_mw, e_valid} = {p_alu_chk, p_rw, p_mr, p_mw, p_valid};
        end
        #6;
        check_comb();  // 1 before the edge
        @(posedge clk);
        #1;
        check_ex();
    endtask

    task automatic write_and_step(input int idx, input logic [31:0] data, ins, pc);
        wb_write_en = 1'b1;
        wb_idx = 5'(idx);
        wb_data = data;
        if (idx != 0) mirror[idx] = data;  // r0 ignores writes
        step_row(ins, pc, 1'b0, 1'b0);
        wb_write_en = 1'b0;
    endtask

    initial begin
        logic [31:0] w;
        lfsr_state = 32'h28f12794;
        {rst_n, stall, flush, wb_write_en} = 4'b0000;
        {id_instruction, id_pc, wb_data, wb_idx} = '0;
        for (int i = 0; i < 32; i++) mirror[i] = '0;
        load_bubble();
        add_row(r_ins(fn_add, 5'd1, 5'd2, 5'd3), 32'h00400000, 1'b0, 1'b0);
        add_row(r_ins(fn_sub, 5'd4, 5'd5, 5'd6), 32'h00400004, 1'b0, 1'b0);
        add_row(r_ins(fn_and, 5'd7, 5'd8, 5'd9), 32'h00400008, 1'b0, 1'b0);
        add_row(r_ins(fn_or, 5'd10, 5'd11, 5'd12), 32'h0040000c, 1'b0, 1'b0);
        add_row(r_ins(fn_xor, 5'd13, 5'd14, 5'd15), 32'h00400010, 1'b0, 1'b0);
        add_row(r_ins(fn_slt, 5'd16, 5'd17, 5'd18), 32'h00400014, 1'b0, 1'b0);
        add_row(r_ins(fn_sll, 5'd0, 5'd20, 5'd21), 32'h00400018, 1'b0, 1'b0);
        add_row(i_ins(op_addi, 5'd1, 5'd22, 16'h8001), 32'h0040001c, 1'b0, 1'b0);  // sign ext
        add_row(i_ins(op_slti, 5'd2, 5'd23, 16'hfff0), 32'h00400020, 1'b0, 1'b0);
        add_row(i_ins(op_andi, 5'd3, 5'd24, 16'h8f0f), 32'h00400024, 1'b0, 1'b0);  // zero ext
        add_row(i_ins(op_ori, 5'd4, 5'd25, 16'hf00f), 32'h00400028, 1'b0, 1'b0);
        add_row(i_ins(op_xori, 5'd5, 5'd26, 16'h1234), 32'h0040002c, 1'b0, 1'b0);
        add_row(i_ins(op_lui, 5'd0, 5'd27, 16'habcd), 32'h00400030, 1'b0, 1'b0);
        add_row(i_ins(op_lw, 5'd6, 5'd28, 16'hfffc), 32'h00400034, 1'b0, 1'b0);
        add_row(i_ins(op_sw, 5'd7, 5'd29, 16'h0010), 32'h00400038, 1'b0, 1'b0);
        add_row(i_ins(op_beq, 5'd5, 5'd5, 16'h0010), 32'h0040003c, 1'b0, 1'b0);   // taken
        add_row(i_ins(op_beq, 5'd5, 5'd6, 16'hfff8), 32'h00400040, 1'b0, 1'b0);   // missed
        add_row(i_ins(op_bne, 5'd5, 5'd6, 16'h0020), 32'h00400044, 1'b0, 1'b0);
        add_row(i_ins(op_bne, 5'd7, 5'd7, 16'h0020), 32'h00400048, 1'b0, 1'b0);
        add_row(i_ins(op_blez, 5'd6, 5'd0, 16'h0004), 32'h0040004c, 1'b0, 1'b0);  // negative
        add_row(i_ins(op_blez, 5'd5, 5'd0, 16'h0004), 32'h00400050, 1'b0, 1'b0);  // positive
        add_row(i_ins(op_bgtz, 5'd5, 5'd0, 16'hff00), 32'h00400054, 1'b0, 1'b0);
        add_row(i_ins(op_bgtz, 5'd6, 5'd0, 16'hff00), 32'h00400058, 1'b0, 1'b0);
        add_row(i_ins(op_blez, 5'd0, 5'd0, 16'h0008), 32'h0040005c, 1'b0, 1'b0);  // zero
        add_row(j_ins(op_j, 26'h1234567), 32'ha0000060, 1'b0, 1'b0);
        add_row(j_ins(op_jal, 26'h2abcdef), 32'h50001000, 1'b0, 1'b0);
        add_row(r_ins(fn_jr, 5'd6, 5'd0, 5'd0), 32'h00400064, 1'b0, 1'b0);
        add_row(r_ins(fn_add, 5'd1, 5'd2, 5'd3), 32'h00400068, 1'b1, 1'b0);  // stall holds
        add_row(r_ins(fn_sub, 5'd8, 5'd9, 5'd10), 32'h00400068, 1'b1, 1'b0);
        add_row(r_ins(fn_add, 5'd1, 5'd2, 5'd3), 32'h00400068, 1'b0, 1'b1);  // flush
        add_row(i_ins(op_addi, 5'd9, 5'd11, 16'h7fff), 32'h0040006c, 1'b0, 1'b0);
        add_row(r_ins(fn_xor, 5'd12, 5'd13, 5'd14), 32'h00400070, 1'b1, 1'b1);  // both
        add_row({6'h3f, 5'd1, 5'd2, 16'h0000}, 32'h00400074, 1'b0, 1'b0);  // unknown opcode
        add_row(i_ins(op_lw, 5'd31, 5'd30, 16'h0100), 32'h00400078, 1'b0, 1'b0);
        cycle_limit = tbl_ins.size() + 68 + 20;  // reset 2, preload 32, readback 32, bypass 2
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_ex();  // bubble after reset
        for (int i = 1; i < 32; i++) begin
            random_word(w);
            write_and_step(i, w, 32'h0, 32'h0);
        end
        write_and_step(0, 32'hdeadbeef, r_ins(fn_jr, 5'd0, 5'd0, 5'd0), 32'h0);
        for (int i = 0; i < 32; i++) begin
            step_row(r_ins(fn_jr, 5'(i), 5'd0, 5'd0), 32'h1000 + 32'(i), 1'b0, 1'b0);
        end
        // same cycle write and read, these also set known branch operands
        write_and_step(5, 32'h00000123, r_ins(fn_jr, 5'd5, 5'd0, 5'd0), 32'h2000);
        write_and_step(6, 32'hfffffff0, r_ins(fn_add, 5'd6, 5'd6, 5'd1), 32'h2004);
        for (int r = 0; r < tbl_ins.size(); r++) begin
            step_row(tbl_ins[r], tbl_pc[r], tbl_stall[r], tbl_flush[r]);
        end
        $display("closing: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
mips_pkg.sv
control_unit.sv
register_file.sv
condition_check.sv
id_mux.sv
id_ex_reg.sv
decode_stage.sv
tb_decode_stage.sv

// File: run.sh
#!/bin/sh
# build the decode stage testbench with Verilator, run it and scan the log
rm -rf obj_dir sim.log
verilator --binary --timing -f src.f --top-module tb_decode_stage -o tb_decode_stage \
    && ./obj_dir/tb_decode_stage > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TESTBENCH PASSED" sim.log && echo "decode stage simulation passed" \
    || { echo "decode stage simulation failed"; exit 1; }
